//--- files.f
+incdir+verification
rtl/remap_pkg.sv
rtl/row_window_builder.sv
rtl/window_fifo.sv
rtl/patch_remap.sv
rtl/remap_unit.sv
verification/remap_unit_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f files.f --top-module remap_unit_tb -o remap_sim
./obj_dir/remap_sim

//--- verification/remap_model.svh
`ifndef REMAP_MODEL_SVH
`define REMAP_MODEL_SVH

// Columns are {patch_size, stride}, {word, row_start}, then hold
// Hold withholds processor credits from that row until in_ready falls
typedef struct packed {
    remap_pkg::cfg_t      cfg;
    remap_pkg::pixel_in_t data;
    logic                 hold;
} stim_t;

localparam int STIM_LEN = 23;

localparam stim_t STIM [STIM_LEN] = '{
    // Stride 1 for each patch size
    '{'{3'd3, 3'd1}, '{8'ha5, 1'b1}, 1'b0},
    '{'{3'd3, 3'd1}, '{8'h3c, 1'b0}, 1'b0},
    '{'{3'd5, 3'd1}, '{8'h96, 1'b1}, 1'b0},
    '{'{3'd5, 3'd1}, '{8'h5a, 1'b0}, 1'b0},
    '{'{3'd7, 3'd1}, '{8'h7e, 1'b1}, 1'b0},
    '{'{3'd7, 3'd1}, '{8'hd2, 1'b0}, 1'b0},
    // Strides 2 to 7 along one row
    '{'{3'd3, 3'd2}, '{8'h55, 1'b1}, 1'b0},
    '{'{3'd3, 3'd2}, '{8'haa, 1'b0}, 1'b0},
    '{'{3'd5, 3'd3}, '{8'h0f, 1'b0}, 1'b0},
    '{'{3'd7, 3'd4}, '{8'h33, 1'b0}, 1'b0},
    '{'{3'd3, 3'd5}, '{8'hc9, 1'b0}, 1'b0},
    '{'{3'd5, 3'd6}, '{8'he4, 1'b0}, 1'b0},
    '{'{3'd7, 3'd7}, '{8'h18, 1'b1}, 1'b0},
    '{'{3'd7, 3'd7}, '{8'h6b, 1'b0}, 1'b0},
    // Unusable configurations
    '{'{3'd4, 3'd1}, '{8'hff, 1'b0}, 1'b0},
    '{'{3'd3, 3'd0}, '{8'hb2, 1'b0}, 1'b0},
    // Back-pressure run
    '{'{3'd5, 3'd2}, '{8'h19, 1'b1}, 1'b1},
    '{'{3'd5, 3'd2}, '{8'h8e, 1'b0}, 1'b0},
    '{'{3'd5, 3'd2}, '{8'hd4, 1'b0}, 1'b0},
    '{'{3'd5, 3'd2}, '{8'h63, 1'b0}, 1'b0},
    '{'{3'd5, 3'd2}, '{8'hb7, 1'b0}, 1'b0},
    '{'{3'd5, 3'd2}, '{8'h2a, 1'b0}, 1'b0},
    '{'{3'd5, 3'd2}, '{8'hf5, 1'b0}, 1'b0}
};

// Patch of processor p ends at window index RES_W + p
function automatic remap_pkg::patch_bus_t expected_bus(
    input remap_pkg::cfg_t             cfg_in,
    input logic [remap_pkg::WIN_W-1:0] win,
    input int                          col_base
);
    remap_pkg::patch_bus_t bus;
    int size;
    int stride;
    int start_col;
    int first;

    bus = '0;
    size = int'(cfg_in.patch_size);
    stride = int'(cfg_in.stride);
    if ((size == 3 || size == 5 || size == 7) && stride != 0) begin
        for (int p = 0; p < remap_pkg::NUM_PROC; p++) begin
            start_col = col_base + p - (size - 1);
            first = remap_pkg::RES_W + p - (size - 1);
            if (start_col >= 0 && (start_col % stride) == 0) begin
                bus.enable[p] = 1'b1;
                for (int j = 0; j < size; j++) begin
                    bus.patch[p][j] = win[first + j];
                end
            end
        end
    end
    return bus;
endfunction

`endif

//--- verification/remap_unit_tb.sv
`timescale 1ns/1ps

module remap_unit_tb;

    `include "remap_model.svh"

    localparam int CYCLE_LIMIT = 40 * STIM_LEN + 200;
    localparam int LOW_WAIT = 8;
    localparam int PACE_LEN = 64;

    logic                  clk;
    logic                  rst;
    remap_pkg::cfg_t       cfg;
    logic                  in_valid;
    remap_pkg::pixel_in_t  in_data;
    logic                  in_ready;
    logic                  out_valid;
    remap_pkg::patch_bus_t out_bus;
    logic                  out_credit;

    remap_pkg::patch_bus_t exp_q[$];
    bit                    credit_pace [PACE_LEN];
    int                    gaps [STIM_LEN];
    int                    cycles = 0;
    int                    owed = 0;
    int                    hold_outputs = 0;
    int                    hold_accepts = 0;
    logic                  hold = 1'b0;

    remap_unit UUT (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_bus    (out_bus),
        .out_credit (out_credit)
    );

    always #5 clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_bus(input string name, input remap_pkg::patch_bus_t got,
                             input remap_pkg::patch_bus_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Called once in_ready has stayed low with credits withheld
    task automatic release_hold();
        check_flag("out_valid", out_valid, 1'b0);
        if (hold_outputs != remap_pkg::OUT_CREDITS ||
            hold_accepts != remap_pkg::FIFO_DEPTH + remap_pkg::OUT_CREDITS) begin
            $display("Credit hold saw %0d outputs and %0d accepted words before in_ready fell",
                     hold_outputs, hold_accepts);
            stop_run();
        end
        hold = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    ////////////////////
    // Processor side
    ////////////////////

    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_credit = 1'b0;
            if (!hold && owed > 0 && credit_pace[cycles % PACE_LEN]) begin
                out_credit = 1'b1;
                owed--;
            end
            @(negedge clk);
            if (!rst && out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Output arrived with no expected result queued");
                    stop_run();
                end
                check_bus("out_bus", out_bus, exp_q.pop_front());
                owed++;
                if (hold) begin
                    hold_outputs++;
                end
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        stim_t                       row;
        remap_pkg::pixel_word_t      prev_word;
        logic [remap_pkg::RES_W-1:0] res;
        int                          next_col;
        int                          col_base;
        int                          low_cycles;

        void'($urandom(85208));
        for (int i = 0; i < PACE_LEN; i++) begin
            credit_pace[i] = (($urandom % 4) != 0);
        end
        for (int i = 0; i < STIM_LEN; i++) begin
            gaps[i] = $urandom % 3;
        end
        clk = 1'b0;
        rst = 1'b1;
        cfg = STIM[0].cfg;
        in_valid = 1'b0;
        in_data = '0;
        prev_word = '0;
        next_col = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("out_valid", out_valid, 1'b0);

        for (int i = 0; i < STIM_LEN; i++) begin
            row = STIM[i];
            // Configuration changes only with the pipeline drained
            if (row.cfg != cfg || row.hold) begin
                while (exp_q.size() != 0 || owed != 0) begin
                    next_cycle();
                end
                cfg = row.cfg;
            end
            if (row.hold) begin
                hold = 1'b1;
                hold_outputs = 0;
                hold_accepts = 0;
            end
            res = row.data.row_start ? '0 :
                prev_word[remap_pkg::WORD_W-1:remap_pkg::WORD_W-remap_pkg::RES_W];
            col_base = row.data.row_start ? 0 : next_col;
            exp_q.push_back(expected_bus(row.cfg, {row.data.word, res}, col_base));
            prev_word = row.data.word;
            next_col = col_base + remap_pkg::WORD_W;

            in_valid = 1'b1;
            in_data = row.data;
            low_cycles = 0;
            while (!in_ready) begin
                next_cycle();
                if (hold) begin
                    low_cycles++;
                    if (low_cycles == LOW_WAIT) begin
                        release_hold();
                    end
                end
            end
            next_cycle();
            in_valid = 1'b0;
            if (hold) begin
                hold_accepts++;
            end
            repeat (gaps[i]) next_cycle();
        end

        if (hold) begin
            $display("in_ready never fell while credits were withheld");
            stop_run();
        end else begin
            while (exp_q.size() != 0) begin
                next_cycle();
            end
            $display("All checks passed");
            $finish;
        end
    end

endmodule

//--- rtl/remap_unit.sv
`timescale 1ns/1ps

module remap_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  remap_pkg::cfg_t       cfg,
    input  logic                  in_valid,
    input  remap_pkg::pixel_in_t  in_data,
    output logic                  in_ready,
    output logic                  out_valid,
    output remap_pkg::patch_bus_t out_bus,
    input  logic                  out_credit
);

    // Builder to FIFO
    logic                     push;
    remap_pkg::window_entry_t push_entry;
    logic                     credit_ret;

    // FIFO to remapper
    logic                     pop;
    logic                     not_empty;
    remap_pkg::window_entry_t head;

    row_window_builder u_builder (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .push       (push),
        .entry      (push_entry),
        .credit_ret (credit_ret)
    );

    window_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .not_empty  (not_empty),
        .head       (head),
        .credit_ret (credit_ret)
    );

    patch_remap u_remap (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .not_empty  (not_empty),
        .head       (head),
        .pop        (pop),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_bus    (out_bus)
    );

endmodule

//--- rtl/patch_remap.sv
`timescale 1ns/1ps

module patch_remap (
    input  logic                     clk,
    input  logic                     rst,
    input  remap_pkg::cfg_t          cfg,
    input  logic                     not_empty,
    input  remap_pkg::window_entry_t head,
    output logic                     pop,
    input  logic                     out_credit,
    output logic                     out_valid,
    output remap_pkg::patch_bus_t    out_bus
);

    logic [remap_pkg::CRED_W-1:0] credits;
    logic                         cfg_ok;
    remap_pkg::patch_bus_t        bus_next;

    // Pop only when the processors can take the result
    assign pop = not_empty && (credits != '0);

    // Sizes 3, 5, 7 with any nonzero stride
    assign cfg_ok = ((cfg.patch_size == 3'd3) ||
                     (cfg.patch_size == 3'd5) ||
                     (cfg.patch_size == 3'd7)) && (cfg.stride != 3'd0);

    ////////////////////
    // Remap
    ////////////////////

    // Processor p ends its patch at window index RES_W + p
    always_comb begin
        int start_col;
        int start_idx;
        int span;
        logic en;

        bus_next = '0;
        span = int'(cfg.patch_size) - 1;
        for (int p = 0; p < remap_pkg::NUM_PROC; p++) begin
            start_col = int'(head.col_base) + p - span;
            start_idx = remap_pkg::RES_W + p - span;
            // Negative columns fall before the row start
            en = cfg_ok && (start_col >= 0) &&
                 ((start_col % int'(cfg.stride)) == 0);
            bus_next.enable[p] = en;
            for (int j = 0; j < remap_pkg::PATCH_W; j++) begin
                if (en && (j < int'(cfg.patch_size))) begin
                    bus_next.patch[p][j] = head.window.flat[start_idx + j];
                end
            end
        end
    end

    ////////////////////
    // Output stage
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_bus <= bus_next;
        end
    end

    // Spent on pop, returned by the processors
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= remap_pkg::OUT_CREDITS[remap_pkg::CRED_W-1:0];
        end else begin
            credits <= credits
                + {{(remap_pkg::CRED_W-1){1'b0}}, out_credit}
                - {{(remap_pkg::CRED_W-1){1'b0}}, pop};
        end
    end

endmodule

//--- rtl/window_fifo.sv
`timescale 1ns/1ps

module window_fifo (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  remap_pkg::window_entry_t push_entry,
    input  logic                     pop,
    output logic                     not_empty,
    output remap_pkg::window_entry_t head,
    output logic                     credit_ret
);

    typedef logic [$clog2(remap_pkg::FIFO_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(remap_pkg::FIFO_DEPTH+1)-1:0] count_t;

    remap_pkg::window_entry_t mem [remap_pkg::FIFO_DEPTH];
    ptr_t                     wr_ptr;
    ptr_t                     rd_ptr;
    count_t                   count;
    logic                     do_pop;

    assign not_empty = (count != '0);
    assign do_pop = pop && not_empty;

    // Head reads straight from storage
    assign head = mem[rd_ptr];

    ////////////////////
    // Storage
    ////////////////////

    // Producer credits keep pushes within depth
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    ////////////////////
    // Pointers
    ////////////////////

    // Depth is a power of two so pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, do_pop})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
        end
    end

    // Freed slot goes back to the producer
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= do_pop;
        end
    end

endmodule

//--- rtl/row_window_builder.sv
`timescale 1ns/1ps

module row_window_builder (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  remap_pkg::pixel_in_t     in_data,
    output logic                     in_ready,
    output logic                     push,
    output remap_pkg::window_entry_t entry,
    input  logic                     credit_ret
);

    logic [remap_pkg::CRED_W-1:0] credits;
    remap_pkg::pixel_word_t       prev_word;
    logic [remap_pkg::COL_W-1:0]  next_col;
    logic                         accept;
    remap_pkg::window_u           window_next;
    logic [remap_pkg::COL_W-1:0]  col_next;

    // One credit per free FIFO slot
    assign in_ready = (credits != '0);
    assign accept = in_valid && in_ready;

    // Row start drops the residues and restarts the column count
    always_comb begin
        window_next.fields.pixels = in_data.word;
        window_next.fields.residues = in_data.row_start ? '0 :
            prev_word[remap_pkg::WORD_W-1:remap_pkg::WORD_W-remap_pkg::RES_W];
        col_next = in_data.row_start ? '0 : next_col;
    end

    ////////////////////
    // Row state
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_word <= '0;
            next_col <= '0;
            push <= 1'b0;
        end else begin
            push <= accept;
            if (accept) begin
                prev_word <= in_data.word;
                next_col <= col_next + remap_pkg::WORD_W[remap_pkg::COL_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            entry.window <= window_next;
            entry.col_base <= col_next;
        end
    end

    // Credit is taken at accept, the push follows one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= remap_pkg::FIFO_DEPTH[remap_pkg::CRED_W-1:0];
        end else begin
            credits <= credits
                + {{(remap_pkg::CRED_W-1){1'b0}}, credit_ret}
                - {{(remap_pkg::CRED_W-1){1'b0}}, accept};
        end
    end

endmodule

//--- rtl/remap_pkg.sv
package remap_pkg;

    ////////////////////
    // Geometry
    ////////////////////

    // Pixel bits per input word
    localparam int WORD_W = 8;
    // Bits kept from the previous word
    localparam int RES_W = 6;
    localparam int WIN_W = RES_W + WORD_W;
    localparam int NUM_PROC = 8;
    // Widest patch is 7 pixels
    localparam int PATCH_W = 7;
    localparam int COL_W = 10;

    ////////////////////
    // Flow control
    ////////////////////

    localparam int FIFO_DEPTH = 4;
    localparam int CRED_W = 3;
    localparam int OUT_CREDITS = 2;

    typedef logic [WORD_W-1:0] pixel_word_t;

    typedef struct packed {
        pixel_word_t word;
        logic        row_start;
    } pixel_in_t;

    typedef struct packed {
        logic [2:0] patch_size;
        logic [2:0] stride;
    } cfg_t;

    // Same 14 bits, seen as one row or as older residues plus current word
    typedef union packed {
        logic [WIN_W-1:0] flat;
        struct packed {
            pixel_word_t      pixels;
            logic [RES_W-1:0] residues;
        } fields;
    } window_u;

    typedef struct packed {
        window_u          window;
        logic [COL_W-1:0] col_base;
    } window_entry_t;

    typedef struct packed {
        logic [NUM_PROC-1:0]              enable;
        logic [NUM_PROC-1:0][PATCH_W-1:0] patch;
    } patch_bus_t;

endpackage
